// ==== common/exc_pkg.sv ====
`default_nettype none

package exc_pkg;

    // exception type as flagged by the pipeline stages
    typedef enum logic [4:0] {
        et_int             = 5'd0,
        et_itlb_refill     = 5'd1,
        et_itlb_invalid    = 5'd2,
        et_dtlb_rd_refill  = 5'd3,
        et_dtlb_rd_invalid = 5'd4,
        et_dtlb_wr_refill  = 5'd5,
        et_dtlb_wr_invalid = 5'd6,
        et_dtlb_modified   = 5'd7,
        et_adel            = 5'd8,
        et_ades            = 5'd9,
        et_sys             = 5'd10,
        et_bp              = 5'd11,
        et_ri              = 5'd12,
        et_ov              = 5'd13,
        et_no_ex           = 5'd31
    } exc_type_t;

    // architectural cause.exccode values
    typedef enum logic [4:0] {
        ec_int  = 5'd0,
        ec_mod  = 5'd1,
        ec_tlbl = 5'd2,
        ec_tlbs = 5'd3,
        ec_adel = 5'd4,
        ec_ades = 5'd5,
        ec_sys  = 5'd8,
        ec_bp   = 5'd9,
        ec_ri   = 5'd10,
        ec_ov   = 5'd12,
        // unmapped type, same encoding as no_ex
        ec_none = 5'd31
    } exc_code_t;

    // one record per cycle from the memory stage
    typedef struct packed {
        logic        valid;
        logic        inst_mtc0;
        logic        inst_eret;
        logic        bd;
        logic        ex;
        exc_type_t   exc_type;
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic [4:0]  rd;
        logic [2:0]  sel;
    } commit_t;

    // decoded cp0 action for the current cycle
    typedef struct packed {
        logic        mtc0_we;
        logic        eret;
        logic        ex;
        exc_code_t   exc_code;
        // faulting instruction sits in a delay slot
        logic        bd;
        // exception taken with exl clear
        logic        bd_set;
        logic [31:0] epc_value;
        logic        badvaddr_we;
        logic [31:0] badvaddr;
        // {rd, sel}
        logic [7:0]  addr;
    } cp0_event_t;

endpackage

`default_nettype wire

// ==== common/cp0_reg_pkg.sv ====
`default_nettype none

package cp0_reg_pkg;

    // cp0 addresses, {rd, sel}
    localparam logic [7:0] addr_random   = {5'd1, 3'd0};
    localparam logic [7:0] addr_context  = {5'd4, 3'd0};
    localparam logic [7:0] addr_wired    = {5'd6, 3'd0};
    localparam logic [7:0] addr_badvaddr = {5'd8, 3'd0};
    localparam logic [7:0] addr_count    = {5'd9, 3'd0};
    localparam logic [7:0] addr_compare  = {5'd11, 3'd0};
    localparam logic [7:0] addr_status   = {5'd12, 3'd0};
    localparam logic [7:0] addr_cause    = {5'd13, 3'd0};
    localparam logic [7:0] addr_epc      = {5'd14, 3'd0};

    // tlb size sets random/wired width
    localparam int tlb_num = 16;
    localparam int rand_w  = $clog2(tlb_num);

    // timer reset value, tuned for the tick rate
    localparam logic [31:0] compare_reset = 32'h0001_55cc;

    // exception entry points
    localparam logic [31:0] vector_bev    = 32'hbfc0_0380;
    localparam logic [31:0] vector_normal = 32'h8000_0180;

    typedef struct packed {
        logic [2:0] pad_31_29;
        logic       cu0;
        logic [4:0] pad_27_23;
        logic       bev;
        logic [5:0] pad_21_16;
        logic [7:0] im;
        logic [2:0] pad_7_5;
        logic       um;
        logic       pad_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic        bd;
        logic        ti;
        // coprocessor number, always zero here
        logic [1:0]  ce;
        logic [11:0] pad_27_16;
        logic [7:0]  ip;
        logic        pad_7;
        logic [4:0]  exc_code;
        logic [1:0]  pad_1_0;
    } cause_t;

    // boot state, bev set
    localparam status_t status_reset = '{bev: 1'b1, default: '0};

    // mtc0 word, viewed by target register
    typedef union packed {
        logic [31:0] raw;
        status_t     status;
        cause_t      cause;
    } cp0_wdata_u;

    // state seen by the interrupt controller
    typedef struct packed {
        status_t     status;
        cause_t      cause;
        logic [31:0] epc;
    } cp0_state_t;

endpackage

`default_nettype wire

// ==== src/cp0_commit_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_commit_decode (
    input  exc_pkg::commit_t        commit,
    input  logic                    exl,
    output exc_pkg::cp0_event_t     cp0_event,
    output cp0_reg_pkg::cp0_wdata_u wdata
);
    import exc_pkg::*;

    logic adel;
    logic ades;

    assign adel = (commit.exc_type == et_adel);
    assign ades = (commit.exc_type == et_ades);

    // strobes, an exception kills mtc0 and eret
    assign cp0_event.mtc0_we = commit.valid && commit.inst_mtc0 && !commit.ex;
    assign cp0_event.eret    = commit.valid && commit.inst_eret && !commit.ex;
    assign cp0_event.ex      = commit.valid && commit.ex;

    // exc_type to exccode
    always_comb begin
        case (commit.exc_type)
            et_int:             cp0_event.exc_code = ec_int;
            et_itlb_refill,
            et_itlb_invalid,
            et_dtlb_rd_refill,
            et_dtlb_rd_invalid: cp0_event.exc_code = ec_tlbl;
            et_dtlb_wr_refill,
            et_dtlb_wr_invalid: cp0_event.exc_code = ec_tlbs;
            et_dtlb_modified:   cp0_event.exc_code = ec_mod;
            et_adel:            cp0_event.exc_code = ec_adel;
            et_ades:            cp0_event.exc_code = ec_ades;
            et_sys:             cp0_event.exc_code = ec_sys;
            et_bp:              cp0_event.exc_code = ec_bp;
            et_ri:              cp0_event.exc_code = ec_ri;
            et_ov:              cp0_event.exc_code = ec_ov;
            default:            cp0_event.exc_code = ec_none;
        endcase
    end

    // epc and bd only recorded on first-level entry
    assign cp0_event.bd        = commit.bd;
    assign cp0_event.bd_set    = cp0_event.ex && !exl;
    // delay slot points back at the branch
    assign cp0_event.epc_value = commit.bd ? commit.pc - 32'd4 : commit.pc;

    // bad address, misaligned fetch wins over load address
    assign cp0_event.badvaddr_we = cp0_event.ex && (adel || ades);
    always_comb begin
        if (adel && commit.pc[1:0] != 2'b00) begin
            cp0_event.badvaddr = commit.pc;
        end else begin
            cp0_event.badvaddr = commit.alu_result;
        end
    end

    assign cp0_event.addr = {commit.rd, commit.sel};

    // mtc0 data rides on the alu result
    assign wdata.raw = commit.alu_result;

endmodule

`default_nettype wire

// ==== cp0_regs/cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  exc_pkg::cp0_event_t     cp0_event,
    input  cp0_reg_pkg::cp0_wdata_u wdata,
    input  logic [5:0]              ext_int,
    output cp0_reg_pkg::cp0_state_t state,
    output logic [31:0]             rdata
);
    import cp0_reg_pkg::*;

    status_t           status_q;
    cause_t            cause_q;
    logic [31:0]       count_q;
    logic [31:0]       compare_q;
    logic              tick_q;
    logic [31:0]       epc_q;
    logic [31:0]       badvaddr_q;
    logic [rand_w-1:0] random_q;
    logic [rand_w-1:0] random_next;
    logic [rand_w-1:0] wired_q;
    logic [8:0]        pte_base_q;

    logic wr_status;
    logic wr_cause;
    logic wr_count;
    logic wr_compare;
    logic wr_epc;
    logic wr_wired;
    logic wr_context;

    // mtc0 target decode
    assign wr_status  = cp0_event.mtc0_we && cp0_event.addr == addr_status;
    assign wr_cause   = cp0_event.mtc0_we && cp0_event.addr == addr_cause;
    assign wr_count   = cp0_event.mtc0_we && cp0_event.addr == addr_count;
    assign wr_compare = cp0_event.mtc0_we && cp0_event.addr == addr_compare;
    assign wr_epc     = cp0_event.mtc0_we && cp0_event.addr == addr_epc;
    assign wr_wired   = cp0_event.mtc0_we && cp0_event.addr == addr_wired;
    assign wr_context = cp0_event.mtc0_we && cp0_event.addr == addr_context;

    // status, padding bits stay at their reset zero
    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= status_reset;
        end else begin
            if (wr_status) begin
                status_q.cu0 <= wdata.status.cu0;
                status_q.bev <= wdata.status.bev;
                status_q.im  <= wdata.status.im;
                status_q.um  <= wdata.status.um;
                status_q.erl <= wdata.status.erl;
                status_q.ie  <= wdata.status.ie;
            end
            // exl: exception, then eret, then mtc0
            if (cp0_event.ex) begin
                status_q.exl <= 1'b1;
            end else if (cp0_event.eret) begin
                status_q.exl <= 1'b0;
            end else if (wr_status) begin
                status_q.exl <= wdata.status.exl;
            end
        end
    end

    // count steps on every other edge
    always_ff @(posedge clk) begin
        if (reset) begin
            tick_q  <= 1'b0;
            count_q <= '0;
        end else begin
            tick_q <= ~tick_q;
            if (wr_count) begin
                count_q <= wdata.raw;
            end else if (tick_q) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare_q <= compare_reset;
        end else if (wr_compare) begin
            compare_q <= wdata.raw;
        end
    end

    // cause, ce and padding never written
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_q <= '0;
        end else begin
            if (cp0_event.bd_set) begin
                cause_q.bd <= cp0_event.bd;
            end
            // writing compare acks the timer
            if (wr_compare) begin
                cause_q.ti <= 1'b0;
            end else if (count_q == compare_q) begin
                cause_q.ti <= 1'b1;
            end
            // hw lines sampled every cycle, timer shares ip7
            cause_q.ip[7]   <= ext_int[5] | cause_q.ti;
            cause_q.ip[6:2] <= ext_int[4:0];
            // software interrupts
            if (wr_cause) begin
                cause_q.ip[1:0] <= wdata.cause.ip[1:0];
            end
            if (cp0_event.ex) begin
                cause_q.exc_code <= cp0_event.exc_code;
            end
        end
    end

    // epc, exception entry beats mtc0
    always_ff @(posedge clk) begin
        if (cp0_event.bd_set) begin
            epc_q <= cp0_event.epc_value;
        end else if (wr_epc) begin
            epc_q <= wdata.raw;
        end
    end

    // only address errors load badvaddr
    always_ff @(posedge clk) begin
        if (cp0_event.badvaddr_we) begin
            badvaddr_q <= cp0_event.badvaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wired_q <= '0;
        end else if (wr_wired) begin
            wired_q <= wdata.raw[rand_w-1:0];
        end
    end

    // random climbs each cycle, wraps back to wired
    assign random_next = random_q + 1'b1;
    always_ff @(posedge clk) begin
        if (reset) begin
            random_q <= rand_w'(tlb_num - 1);
        end else begin
            random_q <= (wired_q < random_next) ? random_next : wired_q;
        end
    end

    // context pte base only, badvpn2 reads zero
    always_ff @(posedge clk) begin
        if (wr_context) begin
            pte_base_q <= wdata.raw[31:23];
        end
    end

    assign state.status = status_q;
    assign state.cause  = cause_q;
    assign state.epc    = epc_q;

    // mfc0 read mux
    always_comb begin
        case (cp0_event.addr)
            addr_badvaddr: rdata = badvaddr_q;
            addr_count:    rdata = count_q;
            addr_compare:  rdata = compare_q;
            addr_status:   rdata = status_q;
            addr_cause:    rdata = cause_q;
            addr_epc:      rdata = epc_q;
            addr_random:   rdata = {{(32 - rand_w){1'b0}}, random_q};
            addr_wired:    rdata = {{(32 - rand_w){1'b0}}, wired_q};
            addr_context:  rdata = {pte_base_q, 23'd0};
            default:       rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cp0_int_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_int_ctrl (
    input  exc_pkg::cp0_event_t     cp0_event,
    input  cp0_reg_pkg::cp0_state_t state,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc,
    output logic                    int_pending
);
    import cp0_reg_pkg::*;

    logic [7:0] ip_masked;

    // unmasked pending lines
    assign ip_masked = state.cause.ip & state.status.im;

    // global enable, blocked inside a handler
    assign int_pending = state.status.ie && !state.status.exl && (|ip_masked);

    // flush the pipeline on entry or return
    assign redirect_valid = cp0_event.ex || cp0_event.eret;

    always_comb begin
        if (cp0_event.ex) begin
            // boot vector while bev is set
            redirect_pc = state.status.bev ? vector_bev : vector_normal;
        end else begin
            // eret goes back to epc
            redirect_pc = state.epc;
        end
    end

endmodule

`default_nettype wire

// ==== src/cp0_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_top (
    input  logic             clk,
    input  logic             reset,
    input  exc_pkg::commit_t commit,
    input  logic [5:0]       ext_int,
    output logic [31:0]      rdata,
    output logic             redirect_valid,
    output logic [31:0]      redirect_pc,
    output logic             int_pending
);
    import exc_pkg::*;
    import cp0_reg_pkg::*;

    cp0_event_t cp0_event;
    cp0_wdata_u wdata;
    cp0_state_t state;

    // commit record to event, exl fed back from status
    cp0_commit_decode decode_i (
        .commit    (commit),
        .exl       (state.status.exl),
        .cp0_event (cp0_event),
        .wdata     (wdata)
    );

    cp0_regs regs_i (
        .clk       (clk),
        .reset     (reset),
        .cp0_event (cp0_event),
        .wdata     (wdata),
        .ext_int   (ext_int),
        .state     (state),
        .rdata     (rdata)
    );

    cp0_int_ctrl int_ctrl_i (
        .cp0_event      (cp0_event),
        .state          (state),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .int_pending    (int_pending)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int half_period_ns = 5,
    parameter int reset_cycles   = 4
) (
    output logic clk,
    output logic reset
);
    initial clk = 1'b0;
    always #(half_period_ns) clk = ~clk;

    // reset held for a fixed number of rising edges
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/cp0_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;
    import exc_pkg::*;
    import cp0_reg_pkg::*;

    localparam int run_cycles = 20000;

    logic        clk;
    logic        reset;
    commit_t     commit;
    logic [5:0]  ext_int;
    logic [31:0] rdata;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        int_pending;

    // reference model state
    status_t     m_status;
    cause_t      m_cause;
    logic [31:0] m_count, m_compare, m_epc, m_bva;
    logic        m_tick, m_epc_ok, m_bva_ok, m_ctx_ok, m_wired_new;
    logic [3:0]  m_random, m_wired;
    logic [8:0]  m_pte;

    logic [31:0] rng;
    int          word_errs, redirect_errs, bit_errs, other_errs;
    int          wait_cycles;

    tb_clock clock_i (.clk(clk), .reset(reset));

    cp0_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .commit         (commit),
        .ext_int        (ext_int),
        .rdata          (rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .int_pending    (int_pending)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // architectural exccode for each pipeline type
    function automatic logic [4:0] exc_code_of(input exc_type_t t);
        case (t)
            et_int:                                 return 5'd0;
            et_dtlb_modified:                       return 5'd1;
            et_itlb_refill, et_itlb_invalid,
            et_dtlb_rd_refill, et_dtlb_rd_invalid:  return 5'd2;
            et_dtlb_wr_refill, et_dtlb_wr_invalid:  return 5'd3;
            et_adel:                                return 5'd4;
            et_ades:                                return 5'd5;
            et_sys:                                 return 5'd8;
            et_bp:                                  return 5'd9;
            et_ri:                                  return 5'd10;
            et_ov:                                  return 5'd12;
            default:                                return 5'd31;
        endcase
    endfunction

    // mostly implemented registers with status weighted heaviest
    function automatic logic [7:0] pick_addr(input logic [3:0] idx);
        case (idx)
            4'd0:           return addr_badvaddr;
            4'd1:           return addr_count;
            4'd2:           return addr_compare;
            4'd3:           return addr_epc;
            4'd4:           return addr_random;
            4'd5:           return addr_wired;
            4'd6:           return addr_context;
            4'd7, 4'd8:     return addr_cause;
            default:        return addr_status;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            word_errs++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_redirect(input logic got_v, exp_v, input logic [31:0] got_pc,
                                  input logic [31:0] exp_pc, input logic pc_known);
        if (got_v !== exp_v) begin
            redirect_errs++;
            $display("mismatch redirect_valid: got %h expected %h", got_v, exp_v);
        end else if (exp_v && pc_known && got_pc !== exp_pc) begin
            redirect_errs++;
            $display("mismatch redirect_pc: got %h expected %h", got_pc, exp_pc);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            bit_errs++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // expected mfc0 value with known low for registers never written
    task automatic read_model(input logic [7:0] a, output logic [31:0] v, output logic known);
        known = 1'b1;
        case (a)
            addr_badvaddr: begin
                v = m_bva;
                known = m_bva_ok;
            end
            addr_count:    v = m_count;
            addr_compare:  v = m_compare;
            addr_status:   v = m_status;
            addr_cause:    v = m_cause;
            addr_epc:      begin
                v = m_epc;
                known = m_epc_ok;
            end
            addr_random:   v = {28'd0, m_random};
            addr_wired:    v = {28'd0, m_wired};
            addr_context:  begin
                v = {m_pte, 23'd0};
                known = m_ctx_ok;
            end
            default:       v = 32'd0;
        endcase
    endtask

    task automatic drive_random;
        logic [31:0] r0, r1, r2, r3;
        logic [3:0]  op;
        rng = xorshift32(rng);
        r0 = rng;
        rng = xorshift32(rng);
        r1 = rng;
        rng = xorshift32(rng);
        r2 = rng;
        rng = xorshift32(rng);
        r3 = rng;
        op = r0[3:0];
        commit = '0;
        commit.valid = (r0[31:29] != 3'd0);
        commit.ex = (op == 4'd8 || op == 4'd9);
        // eret and exception rows sometimes carry an mtc0 as well
        commit.inst_mtc0 = (op < 4'd6) || (op >= 4'd6 && op <= 4'd9 && r0[4]);
        // an eret under an exception must be dropped
        commit.inst_eret = (op == 4'd6 || op == 4'd7) || (commit.ex && r0[11]);
        commit.bd = r0[5] & r0[6];
        commit.exc_type = exc_type_t'({1'b0, r1[23:20] % 4'd14});
        commit.pc = r2;
        if (r0[7]) begin
            commit.pc[1:0] = 2'b00;
        end
        commit.alu_result = r3;
        if (r0[10:8] != 3'd0) begin
            {commit.rd, commit.sel} = pick_addr(r1[3:0]);
        end else begin
            {commit.rd, commit.sel} = {r1[20:16], r1[2:0]};
        end
        // small timer values so count meets compare often
        if ({commit.rd, commit.sel} == addr_count) begin
            commit.alu_result = {26'd0, r3[5:0]};
        end else if ({commit.rd, commit.sel} == addr_compare) begin
            commit.alu_result = m_count + {28'd0, r3[3:0]};
        end
        if (r0[15:13] == 3'd0) begin
            ext_int = r1[29:24];
        end
    endtask

    task automatic check_outputs;
        logic        ex_now, eret_now, known, exp_int;
        logic [31:0] exp_rd, exp_pc;
        logic [7:0]  a;
        a = {commit.rd, commit.sel};
        ex_now = commit.valid && commit.ex;
        eret_now = commit.valid && commit.inst_eret && !commit.ex;
        read_model(a, exp_rd, known);
        if (known) begin
            check_word($sformatf("rdata at address %h", a), rdata, exp_rd);
        end
        if (a == addr_random && !m_wired_new && rdata[3:0] < m_wired) begin
            other_errs++;
            $display("random read %0d is below wired %0d", rdata[3:0], m_wired);
        end
        exp_pc = ex_now ? (m_status.bev ? vector_bev : vector_normal) : m_epc;
        check_redirect(redirect_valid, ex_now || eret_now, redirect_pc, exp_pc,
                       ex_now || m_epc_ok);
        exp_int = m_status.ie && !m_status.exl && (|(m_cause.ip & m_status.im));
        check_bit("int_pending", int_pending, exp_int);
    endtask

    // one clock edge of the model with all next values taken from current ones
    task automatic step_model;
        logic        we, eret_now, ex_now, bd_set;
        logic [7:0]  a;
        logic [31:0] wd;
        status_t     st;
        cause_t      ca;
        a = {commit.rd, commit.sel};
        wd = commit.alu_result;
        we = commit.valid && commit.inst_mtc0 && !commit.ex;
        eret_now = commit.valid && commit.inst_eret && !commit.ex;
        ex_now = commit.valid && commit.ex;
        bd_set = ex_now && !m_status.exl;
        st = m_status;
        ca = m_cause;
        if (we && a == addr_status) begin
            st.cu0 = wd[28];
            st.bev = wd[22];
            st.im = wd[15:8];
            st.um = wd[4];
            st.erl = wd[2];
            st.ie = wd[0];
        end
        if (ex_now) st.exl = 1'b1;
        else if (eret_now) st.exl = 1'b0;
        else if (we && a == addr_status) st.exl = wd[1];
        if (bd_set) ca.bd = commit.bd;
        if (we && a == addr_compare) ca.ti = 1'b0;
        else if (m_count == m_compare) ca.ti = 1'b1;
        ca.ip[7] = ext_int[5] | m_cause.ti;
        ca.ip[6:2] = ext_int[4:0];
        if (we && a == addr_cause) ca.ip[1:0] = wd[9:8];
        if (ex_now) ca.exc_code = exc_code_of(commit.exc_type);
        if (bd_set) begin
            m_epc = commit.bd ? commit.pc - 32'd4 : commit.pc;
            m_epc_ok = 1'b1;
        end else if (we && a == addr_epc) begin
            m_epc = wd;
            m_epc_ok = 1'b1;
        end
        if (ex_now && (commit.exc_type == et_adel || commit.exc_type == et_ades)) begin
            m_bva = (commit.exc_type == et_adel && commit.pc[1:0] != 2'b00) ? commit.pc : wd;
            m_bva_ok = 1'b1;
        end
        if (we && a == addr_count) m_count = wd;
        else if (m_tick) m_count = m_count + 32'd1;
        m_tick = !m_tick;
        if (we && a == addr_compare) m_compare = wd;
        // random wraps from the top or jumps up to a newly raised wired
        if (m_random == 4'd15 || m_random < m_wired) m_random = m_wired;
        else m_random = m_random + 4'd1;
        m_wired_new = we && a == addr_wired;
        if (m_wired_new) m_wired = wd[3:0];
        if (we && a == addr_context) begin
            m_pte = wd[31:23];
            m_ctx_ok = 1'b1;
        end
        m_status = st;
        m_cause = ca;
    endtask

    initial begin
        commit = '0;
        ext_int = '0;
        rng = 32'd39315;
        word_errs = 0;
        redirect_errs = 0;
        bit_errs = 0;
        other_errs = 0;
        wait_cycles = 0;
        // values after reset
        m_status = '0;
        m_status.bev = 1'b1;
        m_cause = '0;
        m_count = '0;
        m_compare = compare_reset;
        m_tick = 1'b0;
        m_random = 4'd15;
        m_wired = '0;
        m_wired_new = 1'b0;
        m_epc = '0;
        m_bva = '0;
        m_pte = '0;
        m_epc_ok = 1'b0;
        m_bva_ok = 1'b0;
        m_ctx_ok = 1'b0;
        #1;
        while (reset !== 1'b0 && wait_cycles < 20) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (reset !== 1'b0) begin
            $display("reset was not released within 20 cycles");
            $display("Some tests failed");
        end else begin
            // inputs change 1 ns after the edge and outputs are sampled mid-cycle
            for (int cyc = 0; cyc < run_cycles; cyc++) begin
                drive_random();
                #4;
                check_outputs();
                step_model();
                @(posedge clk);
                #1;
            end
            $display("errors: rdata %0d, redirect %0d, int_pending %0d, other %0d",
                     word_errs, redirect_errs, bit_errs, other_errs);
            if (word_errs + redirect_errs + bit_errs + other_errs == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cp0_sys.f ====
common/exc_pkg.sv
common/cp0_reg_pkg.sv
src/cp0_commit_decode.sv
cp0_regs/cp0_regs.sv
src/cp0_int_ctrl.sv
src/cp0_top.sv
bench/tb_clock.sv
bench/cp0_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0 -Wno-fatal
TOP       := cp0_tb
FILELIST  := cp0_sys.f
OBJDIR    := obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJDIR)
